// ==== ooo_core.f ====
source/ooo_pkg.sv
source/register_status.sv
source/reservation_station.sv
source/alu_dispatch.sv
source/reorder_buffer.sv
source/ooo_core.sv
tests/ooo_core_checker.sv
tests/ooo_core_monitor.sv
tests/ooo_core_tb.sv

// ==== source/alu_dispatch.sv ====
module alu_dispatch (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  ooo_pkg::rs_entry_t [ooo_pkg::rs_size-1:0] entries,
	input  logic [ooo_pkg::rs_size-1:0] ready,
	output logic [ooo_pkg::rs_size-1:0] free_strobe,
	output ooo_pkg::exec_result_t result
);
	import ooo_pkg::*;

	logic pick;
	rs_idx_t pick_idx;
	word_t a;
	word_t b;
	word_t alu_out;

	// fixed priority, lowest ready index goes first
	always_comb
	begin
		pick = 1'b0;
		pick_idx = '0;
		for (int i = rs_size - 1; i >= 0; i--)
		begin
			if (ready[i])
			begin
				pick = 1'b1;
				pick_idx = rs_idx_t'(i);
			end
		end
		free_strobe = '0;
		free_strobe[pick_idx] = pick;
	end

	assign a = entries[pick_idx].r1.value;
	assign b = entries[pick_idx].r2.value;

	// single-cycle alu
	always_comb
	begin
		case (entries[pick_idx].op)
			op_add: alu_out = a + b;
			op_sub: alu_out = a - b;
			op_and: alu_out = a & b;
			op_or: alu_out = a | b;
			op_xor: alu_out = a ^ b;
			// shift amount from the low five bits
			op_sll: alu_out = a << b[4:0];
			op_srl: alu_out = a >> b[4:0];
			op_slt: alu_out = word_t'($signed(a) < $signed(b));
			// immediate already sits in r1
			op_li: alu_out = a;
			default: alu_out = '0;
		endcase
	end

	// result register toward the rob, dropped on flush
	always_ff @(posedge clk)
	begin
		if (rst || flush)
			result <= '0;
		else
			result <= '{valid: pick, tag: entries[pick_idx].dest, value: alu_out};
	end

endmodule

// ==== source/ooo_core.sv ====
module ooo_core (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic issue,
	input  ooo_pkg::issue_t issue_insn,
	output logic issue_ready,
	output logic commit_valid,
	output ooo_pkg::reg_idx_t commit_rd,
	output ooo_pkg::word_t commit_value
);
	import ooo_pkg::*;

	logic issue_fire;
	logic run_q;
	logic rob_full;
	operand_t src1;
	operand_t src2;
	rob_tag_t alloc_tag;
	rob_tag_t commit_tag;
	rob_bcast_t [rob_size-1:0] rob_bcast;
	rs_entry_t [rs_size-1:0] rs_entries;
	logic [rs_size-1:0] rs_ready;
	logic [rs_size-1:0] rs_free;
	rs_cnt_t rs_avail;
	exec_result_t exec_res;

	// holds issue off for the first cycle out of reset
	always_ff @(posedge clk)
	begin
		if (rst)
			run_q <= 1'b0;
		else
			run_q <= 1'b1;
	end

	// room in both a station and the rob
	assign issue_ready = run_q && (rs_avail != '0) && !rob_full;
	assign issue_fire = issue && issue_ready && !flush;

	register_status regs_i (.clk, .rst, .flush, .issue_fire, .issue_insn, .alloc_tag,
		.rob_bcast, .commit_valid, .commit_tag, .commit_rd, .commit_value, .src1, .src2);

	reservation_station rs_i (.clk, .rst, .flush, .load(issue_fire), .op(issue_insn.op),
		.dest(alloc_tag), .r1(src1), .r2(src2), .rob_bcast, .free_strobe(rs_free),
		.entries(rs_entries), .ready(rs_ready), .num_available(rs_avail));

	alu_dispatch alu_i (.clk, .rst, .flush, .entries(rs_entries), .ready(rs_ready),
		.free_strobe(rs_free), .result(exec_res));

	reorder_buffer rob_i (.clk, .rst, .flush, .alloc(issue_fire), .alloc_rd(issue_insn.rd),
		.result(exec_res), .alloc_tag, .full(rob_full), .rob_bcast, .commit_valid,
		.commit_tag, .commit_rd, .commit_value);

endmodule

// ==== source/ooo_pkg.sv ====
package ooo_pkg;

	// datapath and structure sizes
	localparam int xlen = 32;
	localparam int num_regs = 32;
	localparam int rs_size = 4;
	localparam int rob_size = 8;

	// derived index and counter widths
	localparam int rob_tag_w = $clog2(rob_size);
	localparam int reg_idx_w = $clog2(num_regs);
	localparam int rs_idx_w = $clog2(rs_size);
	localparam int rs_cnt_w = $clog2(rs_size + 1);
	localparam int rob_cnt_w = $clog2(rob_size + 1);

	typedef logic [xlen-1:0] word_t;
	typedef logic [rob_tag_w-1:0] rob_tag_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;
	typedef logic [rs_idx_w-1:0] rs_idx_t;
	typedef logic [rs_cnt_w-1:0] rs_cnt_t;
	typedef logic [rob_cnt_w-1:0] rob_cnt_t;

	// register-register ops plus load-immediate
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or  = 4'd3,
		op_xor = 4'd4,
		op_sll = 4'd5,
		op_srl = 4'd6,
		op_slt = 4'd7,
		op_li  = 4'd8
	} alu_op_t;

	// value when busy is low, otherwise wait on tag
	typedef struct packed {
		logic     busy;
		word_t    value;
		rob_tag_t tag;
	} operand_t;

	// instruction as seen by the issue stage
	typedef struct packed {
		alu_op_t  op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t    imm;
	} issue_t;

	typedef struct packed {
		logic     valid;
		alu_op_t  op;
		rob_tag_t dest;
		operand_t r1;
		operand_t r2;
	} rs_entry_t;

	// one slot of the rob broadcast, indexed by tag
	typedef struct packed {
		logic  filled_in;
		word_t value;
	} rob_bcast_t;

	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    value;
	} exec_result_t;

endpackage

// ==== source/register_status.sv ====
module register_status (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic issue_fire,
	input  ooo_pkg::issue_t issue_insn,
	input  ooo_pkg::rob_tag_t alloc_tag,
	input  ooo_pkg::rob_bcast_t [ooo_pkg::rob_size-1:0] rob_bcast,
	input  logic commit_valid,
	input  ooo_pkg::rob_tag_t commit_tag,
	input  ooo_pkg::reg_idx_t commit_rd,
	input  ooo_pkg::word_t commit_value,
	output ooo_pkg::operand_t src1,
	output ooo_pkg::operand_t src2
);
	import ooo_pkg::*;

	// architectural state
	word_t regs [num_regs];
	// rename state, one producer tag per register
	logic [num_regs-1:0] pend;
	rob_tag_t pend_tag [num_regs];

	// operand lookup with bypass from commit port and filled rob slots
	function automatic operand_t read_src(reg_idx_t idx);
		operand_t opnd;
		rob_tag_t t;
		t = pend_tag[idx];
		opnd = '{busy: 1'b0, value: regs[idx], tag: '0};
		if (idx == '0)
			opnd.value = '0;
		else if (pend[idx])
		begin
			// the committing slot is already gone from the rob
			if (commit_valid && commit_tag == t)
				opnd.value = commit_value;
			else if (rob_bcast[t].filled_in)
				opnd.value = rob_bcast[t].value;
			else
				opnd = '{busy: 1'b1, value: '0, tag: t};
		end
		return opnd;
	endfunction

	always_comb
	begin
		// li carries its immediate on both operands
		if (issue_insn.op == op_li)
		begin
			src1 = '{busy: 1'b0, value: issue_insn.imm, tag: '0};
			src2 = '{busy: 1'b0, value: issue_insn.imm, tag: '0};
		end
		else
		begin
			src1 = read_src(issue_insn.rs1);
			src2 = read_src(issue_insn.rs2);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pend <= '0;
			for (int i = 0; i < num_regs; i++)
			begin
				regs[i] <= '0;
				pend_tag[i] <= '0;
			end
		end
		else
		begin
			// in-order writeback; x0 never written
			if (commit_valid)
			begin
				if (commit_rd != '0)
					regs[commit_rd] <= commit_value;
				// only drop the tag if no younger writer renamed it
				if (pend_tag[commit_rd] == commit_tag)
					pend[commit_rd] <= 1'b0;
			end
			// flush forgets every in-flight producer
			if (flush)
				pend <= '0;
			else if (issue_fire && issue_insn.rd != '0)
			begin
				// newest writer wins over a same-edge commit
				pend[issue_insn.rd] <= 1'b1;
				pend_tag[issue_insn.rd] <= alloc_tag;
			end
		end
	end

endmodule

// ==== source/reorder_buffer.sv ====
module reorder_buffer (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic alloc,
	input  ooo_pkg::reg_idx_t alloc_rd,
	input  ooo_pkg::exec_result_t result,
	output ooo_pkg::rob_tag_t alloc_tag,
	output logic full,
	output ooo_pkg::rob_bcast_t [ooo_pkg::rob_size-1:0] rob_bcast,
	output logic commit_valid,
	output ooo_pkg::rob_tag_t commit_tag,
	output ooo_pkg::reg_idx_t commit_rd,
	output ooo_pkg::word_t commit_value
);
	import ooo_pkg::*;

	// per-slot control
	logic [rob_size-1:0] valid;
	logic [rob_size-1:0] filled;
	// per-slot payload
	reg_idx_t dest_rd [rob_size];
	word_t value [rob_size];

	rob_tag_t head;
	rob_tag_t tail;
	rob_cnt_t count;
	logic retire;

	// tail is the tag handed to the issuing instruction
	assign alloc_tag = tail;
	assign full = (count == rob_cnt_t'(rob_size));
	// head leaves once its result is in
	assign retire = valid[head] && filled[head];

	// broadcast every filled slot to the stations and the issue bypass
	always_comb
	begin
		for (int i = 0; i < rob_size; i++)
		begin
			rob_bcast[i].filled_in = valid[i] && filled[i];
			rob_bcast[i].value = value[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			valid <= '0;
			filled <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			commit_valid <= 1'b0;
			commit_tag <= '0;
			commit_rd <= '0;
			commit_value <= '0;
		end
		else
		begin
			// tail slot is always free when alloc is allowed
			if (alloc)
			begin
				valid[tail] <= 1'b1;
				filled[tail] <= 1'b0;
				dest_rd[tail] <= alloc_rd;
				tail <= tail + 1'b1;
			end
			// alu writeback
			if (result.valid && valid[result.tag])
			begin
				filled[result.tag] <= 1'b1;
				value[result.tag] <= result.value;
			end
			// registered commit port with one retire per cycle
			commit_valid <= retire;
			if (retire)
			begin
				valid[head] <= 1'b0;
				filled[head] <= 1'b0;
				commit_tag <= head;
				commit_rd <= dest_rd[head];
				commit_value <= value[head];
				head <= head + 1'b1;
			end
			count <= count + rob_cnt_t'(alloc) - rob_cnt_t'(retire);
		end
	end

endmodule

// ==== source/reservation_station.sv ====
module reservation_station (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic load,
	input  ooo_pkg::alu_op_t op,
	input  ooo_pkg::rob_tag_t dest,
	input  ooo_pkg::operand_t r1,
	input  ooo_pkg::operand_t r2,
	input  ooo_pkg::rob_bcast_t [ooo_pkg::rob_size-1:0] rob_bcast,
	input  logic [ooo_pkg::rs_size-1:0] free_strobe,
	output ooo_pkg::rs_entry_t [ooo_pkg::rs_size-1:0] entries,
	output logic [ooo_pkg::rs_size-1:0] ready,
	output ooo_pkg::rs_cnt_t num_available
);
	import ooo_pkg::*;

	rs_idx_t load_idx;
	logic load_hit;

	// lowest free slot for the next issue
	always_comb
	begin
		load_idx = '0;
		load_hit = 1'b0;
		for (int i = rs_size - 1; i >= 0; i--)
		begin
			if (!entries[i].valid)
			begin
				load_idx = rs_idx_t'(i);
				load_hit = 1'b1;
			end
		end
	end

	// free count and per-slot readiness
	always_comb
	begin
		num_available = '0;
		for (int i = 0; i < rs_size; i++)
		begin
			if (!entries[i].valid)
				num_available = num_available + rs_cnt_t'(1);
			// both operands resolved
			ready[i] = entries[i].valid && !entries[i].r1.busy && !entries[i].r2.busy;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			entries <= '0;
		end
		else
		begin
			for (int i = 0; i < rs_size; i++)
			begin
				// wakeup, each busy operand looks at its own tag's slot
				if (entries[i].valid && entries[i].r1.busy &&
					rob_bcast[entries[i].r1.tag].filled_in)
				begin
					entries[i].r1.value <= rob_bcast[entries[i].r1.tag].value;
					entries[i].r1.busy <= 1'b0;
				end
				if (entries[i].valid && entries[i].r2.busy &&
					rob_bcast[entries[i].r2.tag].filled_in)
				begin
					entries[i].r2.value <= rob_bcast[entries[i].r2.tag].value;
					entries[i].r2.busy <= 1'b0;
				end
				// slot taken by the alu this cycle
				if (free_strobe[i])
					entries[i].valid <= 1'b0;
			end

			// new instruction never lands on a slot being freed
			if (load && load_hit)
			begin
				entries[load_idx].valid <= 1'b1;
				entries[load_idx].op <= op;
				entries[load_idx].dest <= dest;
				entries[load_idx].r1 <= r1;
				entries[load_idx].r2 <= r2;
			end
		end
	end

endmodule

// ==== tests/ooo_core_checker.sv ====
module ooo_core_checker (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic commit_valid,
	input logic issue_ready,
	input logic rob_full
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of assertion failures so far
	int unsigned assert_fails = 0;

	// first cycle out of reset is quiet on both sides
	reset_quiet: assert property (@(posedge clk) rst |=> !commit_valid && !issue_ready)
	else
	begin
		assert_fails++;
		$error("commit_valid or issue_ready high in the cycle after reset");
	end

	// a flush kills the commit that would follow it
	flush_quiet: assert property (@(posedge clk) disable iff (rst) flush |=> !commit_valid)
	else
	begin
		assert_fails++;
		$error("commit_valid high in the cycle after a flush");
	end

	// no issue while every rob slot holds an instruction
	full_blocks: assert property (@(posedge clk) disable iff (rst) rob_full |-> !issue_ready)
	else
	begin
		assert_fails++;
		$error("issue_ready high while the reorder buffer is full");
	end

endmodule

// fullness comes from the slot valid bits rather than the count
bind ooo_core ooo_core_checker chk_i (.clk, .rst, .flush, .commit_valid, .issue_ready,
	.rob_full(&rob_i.valid));

// ==== tests/ooo_core_monitor.sv ====
module ooo_core_monitor (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic commit_valid,
	input ooo_pkg::reg_idx_t commit_rd,
	input ooo_pkg::word_t commit_value
);
	timeunit 1ns;
	timeprecision 100ps;
	import ooo_pkg::*;

	// accepted but not yet committed, oldest first
	issue_t issued [$];
	// sequential register model, x0 never written
	word_t model [num_regs];

	string test_name = "none";
	int test_commits = 0;
	int test_errors = 0;
	int commits_total = 0;
	int errors_total = 0;
	int dropped_total = 0;

	initial
	begin
		for (int i = 0; i < num_regs; i++)
			model[i] = '0;
	end

	// architectural result of one instruction on the model
	function automatic word_t ref_result(issue_t insn);
		word_t a;
		word_t b;
		word_t r;
		a = model[insn.rs1];
		b = model[insn.rs2];
		case (insn.op)
			op_add: r = a + b;
			op_sub: r = a - b;
			op_and: r = a & b;
			op_or: r = a | b;
			op_xor: r = a ^ b;
			op_sll: r = a << b[4:0];
			op_srl: r = a >> b[4:0];
			op_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			op_li: r = insn.imm;
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic int outstanding();
		return issued.size();
	endfunction

	task automatic note_issue(input issue_t insn);
		issued.push_back(insn);
	endtask

	task automatic note_error();
		test_errors++;
		errors_total++;
	endtask

	task automatic report_problem(input string msg);
		$display("test %s: %s", test_name, msg);
		note_error();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_commits = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (issued.size() != 0)
		begin
			report_problem($sformatf("%0d accepted instructions never committed",
				issued.size()));
			issued.delete();
		end
		$display("test %s finished: %0d commits checked, %0d problems", test_name,
			test_commits, test_errors);
	endtask

	// compare one commit with the oldest outstanding instruction
	task automatic check_commit();
		issue_t insn;
		word_t want;
		if (issued.size() == 0)
		begin
			report_problem($sformatf("commit of x%0d with no instruction outstanding",
				commit_rd));
		end
		else
		begin
			insn = issued.pop_front();
			want = ref_result(insn);
			test_commits++;
			commits_total++;
			if (commit_rd !== insn.rd || commit_value !== want)
			begin
				$display("FAIL %s: expected x%0d=%h, actual x%0d=%h", test_name, insn.rd,
					want, commit_rd, commit_value);
				note_error();
			end
			if (insn.rd != '0)
				model[insn.rd] = want;
		end
	endtask

	// mid-cycle sampling, everything registered has settled
	always @(negedge clk)
	begin
		if (!rst && commit_valid)
			check_commit();
		// a commit in the flush cycle is real, the rest is gone
		if (!rst && flush)
		begin
			dropped_total += issued.size();
			issued.delete();
		end
	end

endmodule

// ==== tests/ooo_core_tb.sv ====
module ooo_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import ooo_pkg::*;

	// instruction counts per program
	localparam int n_li_ops = 14;
	localparam int n_chain = 10;
	localparam int n_burst = 16;
	localparam int n_flush = 8;
	localparam int n_random = 200;
	localparam int total_insns = n_li_ops + n_chain + n_burst + n_flush + n_random;
	localparam int cycle_limit = 40 * total_insns + 200;
	localparam int drain_limit = 200;

	logic clk;
	logic rst;
	logic flush;
	logic issue;
	issue_t issue_insn;
	logic issue_ready;
	logic commit_valid;
	reg_idx_t commit_rd;
	word_t commit_value;

	logic [31:0] lfsr = 32'hb171;
	int cycles = 0;
	int stall_cycles = 0;
	int total_errors;

	ooo_core dut_i (.clk, .rst, .flush, .issue, .issue_insn, .issue_ready, .commit_valid,
		.commit_rd, .commit_value);

	ooo_core_monitor mon_i (.clk, .rst, .flush, .commit_valid, .commit_rd, .commit_value);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// hard stop in case the core wedges
	initial
	begin
		while (cycles <= cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still going after %0d cycles", cycles);
		$display("Errors found");
		$finish;
	end

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int k = 0; k < n; k++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic issue_t make_insn(alu_op_t op, int rd, int rs1, int rs2, word_t imm);
		issue_t insn;
		insn.op = op;
		insn.rd = reg_idx_t'(rd);
		insn.rs1 = reg_idx_t'(rs1);
		insn.rs2 = reg_idx_t'(rs2);
		insn.imm = imm;
		return insn;
	endfunction

	// registers x0..x7 only so dependencies are frequent
	function automatic issue_t random_insn();
		issue_t insn;
		insn.op = alu_op_t'(4'(take_bits(4) % 9));
		insn.rd = reg_idx_t'(take_bits(3));
		insn.rs1 = reg_idx_t'(take_bits(3));
		insn.rs2 = reg_idx_t'(take_bits(3));
		insn.imm = take_bits(32);
		return insn;
	endfunction

	// hold the strobe until the core takes it
	task automatic issue_one(input issue_t insn);
		issue = 1'b1;
		issue_insn = insn;
		@(negedge clk);
		while (!issue_ready)
		begin
			stall_cycles++;
			@(negedge clk);
		end
		@(posedge clk);
		#5;
		mon_i.note_issue(insn);
		issue = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (mon_i.outstanding() != 0 && waited < drain_limit)
		begin
			@(posedge clk);
			#5;
			waited++;
		end
	endtask

	// a few spare cycles so a stray commit is still caught
	task automatic finish_test();
		drain();
		repeat (3) @(posedge clk);
		#5;
		mon_i.end_test();
	endtask

	task automatic li_then_independent();
		mon_i.start_test("li_independent");
		issue_one(make_insn(op_li, 1, 0, 0, 32'h0000_1234));
		issue_one(make_insn(op_li, 2, 0, 0, 32'h0000_00ff));
		issue_one(make_insn(op_li, 3, 0, 0, 32'h8000_0001));
		issue_one(make_insn(op_li, 4, 0, 0, 32'h0000_0004));
		issue_one(make_insn(op_li, 5, 0, 0, 32'hffff_fff0));
		issue_one(make_insn(op_li, 6, 0, 0, 32'h0f0f_0f0f));
		issue_one(make_insn(op_add, 7, 1, 2, '0));
		issue_one(make_insn(op_sub, 8, 2, 1, '0));
		issue_one(make_insn(op_and, 9, 3, 6, '0));
		issue_one(make_insn(op_or, 10, 6, 2, '0));
		issue_one(make_insn(op_xor, 11, 5, 6, '0));
		issue_one(make_insn(op_sll, 12, 3, 4, '0));
		issue_one(make_insn(op_srl, 13, 5, 4, '0));
		issue_one(make_insn(op_slt, 14, 5, 1, '0));
		finish_test();
	endtask

	// each op reads the one before and x0 writes must not stick
	task automatic dependent_chains();
		mon_i.start_test("dependent_chain");
		issue_one(make_insn(op_li, 1, 0, 0, 32'd5));
		issue_one(make_insn(op_add, 2, 1, 1, '0));
		issue_one(make_insn(op_sub, 3, 2, 1, '0));
		issue_one(make_insn(op_xor, 4, 3, 2, '0));
		issue_one(make_insn(op_add, 0, 4, 4, '0));
		issue_one(make_insn(op_or, 5, 0, 4, '0));
		issue_one(make_insn(op_sll, 5, 5, 1, '0));
		issue_one(make_insn(op_li, 7, 0, 0, 32'hffff_ffff));
		issue_one(make_insn(op_slt, 6, 7, 5, '0));
		issue_one(make_insn(op_srl, 7, 7, 1, '0));
		finish_test();
	endtask

	// long dependent run fills the stations and stalls issue
	task automatic backpressure_burst();
		mon_i.start_test("backpressure");
		stall_cycles = 0;
		issue_one(make_insn(op_li, 20, 0, 0, 32'd1));
		issue_one(make_insn(op_li, 21, 0, 0, 32'd3));
		for (int i = 0; i < n_burst - 2; i++)
			issue_one(make_insn((i % 2 != 0) ? op_xor : op_add, 20 + (i % 2), 20, 21, '0));
		if (stall_cycles == 0)
			mon_i.report_problem("issue_ready never dropped during the burst");
		finish_test();
	endtask

	task automatic flush_batch();
		int dropped_before;
		mon_i.start_test("flush");
		issue_one(make_insn(op_li, 10, 0, 0, 32'h111));
		issue_one(make_insn(op_li, 11, 0, 0, 32'h222));
		issue_one(make_insn(op_li, 12, 0, 0, 32'h444));
		drain();
		dropped_before = mon_i.dropped_total;
		issue_one(make_insn(op_li, 10, 0, 0, 32'hdead_beef));
		issue_one(make_insn(op_add, 11, 10, 10, '0));
		issue_one(make_insn(op_li, 12, 0, 0, 32'd7));
		// flush in the cycle right after the batch
		flush = 1'b1;
		@(posedge clk);
		#5;
		flush = 1'b0;
		if (mon_i.dropped_total - dropped_before != 3)
			mon_i.report_problem("flush did not discard the whole batch");
		// must see the values from before the batch
		issue_one(make_insn(op_add, 13, 10, 11, '0));
		issue_one(make_insn(op_or, 14, 12, 10, '0));
		finish_test();
	endtask

	// bursts of 1..8 with idle gaps of 0..3 cycles
	task automatic random_program();
		int n;
		int burst;
		int gap;
		mon_i.start_test("random");
		n = 0;
		while (n < n_random)
		begin
			burst = int'(take_bits(3)) + 1;
			for (int k = 0; k < burst && n < n_random; k++)
			begin
				issue_one(random_insn());
				n++;
			end
			gap = int'(take_bits(2));
			repeat (gap)
			begin
				@(posedge clk);
				#5;
			end
		end
		finish_test();
	endtask

	initial
	begin
		rst = 1'b1;
		flush = 1'b0;
		issue = 1'b0;
		issue_insn = '0;
		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;
		li_then_independent();
		dependent_chains();
		backpressure_burst();
		flush_batch();
		random_program();
		total_errors = mon_i.errors_total + int'(dut_i.chk_i.assert_fails);
		$display("commits checked %0d, flushed %0d, check errors %0d, assertion failures %0d",
			mon_i.commits_total, mon_i.dropped_total, mon_i.errors_total,
			dut_i.chk_i.assert_fails);
		if (total_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
